//--- verilog/clock_pkg.sv
// Shared types and constants for the digital clock
//   hms_t, mode_e, field_e, btn_t, edit_t, seg_t
//   Count limits, divider ratios, digit count, blank pattern
// Divider ratios are scaled down for simulation

package clock_pkg;

	// ---------------------------------------------------------------------
	// Types
	// ---------------------------------------------------------------------
	typedef struct packed {
		logic [5:0] hour;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		FIELD_SEC  = 2'd0,
		FIELD_MIN  = 2'd1,
		FIELD_HOUR = 2'd2
	} field_e;

	// Raw button levels or one-cycle press pulses
	typedef struct packed {
		logic mode;
		logic field;
		logic inc;
		logic alarm_en;
	} btn_t;

	// One-cycle increment pulses per field
	typedef struct packed {
		logic sec;
		logic min;
		logic hour;
	} edit_t;

	// Segments a..g, MSB first, active high
	typedef logic [6:0] seg_t;

	// ---------------------------------------------------------------------
	// Constants
	// ---------------------------------------------------------------------
	localparam logic [5:0] SEC_MAX  = 6'd59;
	localparam logic [5:0] HOUR_MAX = 6'd23;

	localparam int TICKS_PER_SEC  = 40;
	localparam int SCAN_TICKS     = 4;
	localparam int DEBOUNCE_TICKS = 6;
	// Half periods of the beep beat and of the tone
	localparam int BEEP_TICKS     = 16;
	localparam int TONE_TICKS     = 2;

	localparam int   NUM_DIGITS = 6;
	localparam seg_t SEG_BLANK  = 7'b000_0000;

endpackage

//--- verilog/rate_divider.sv
// Free-running modulo-DIVIDE counter
// Emits a one-cycle strobe each time the count wraps

`timescale 1ns/1ps

module rate_divider #(
	parameter int DIVIDE = 4
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

	logic [CW-1:0] cnt;

	// First strobe lands DIVIDE cycles out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == CW'(DIVIDE - 1)) begin
			cnt    <= '0;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

//--- verilog/button_debounce.sv
// Push-button conditioning for one input
//   Two-flop synchronizer
//   Stability counter ahead of the debounced level
//   Rising-edge press pulse, one clk wide

`timescale 1ns/1ps

module button_debounce (
	input  logic clk,
	input  logic rst_n,
	input  logic i_btn,
	output logic o_press
);

	localparam int CW = $clog2(clock_pkg::DEBOUNCE_TICKS + 1);

	logic [1:0]    sync_q;
	logic          stable_q;
	logic [CW-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			sync_q <= 2'b00;
		end else begin
			sync_q <= {sync_q[0], i_btn};
		end
	end

	// Level must differ for DEBOUNCE_TICKS samples in a row
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			cnt      <= '0;
			stable_q <= 1'b0;
			o_press  <= 1'b0;
		end else if (sync_q[1] == stable_q) begin
			cnt     <= '0;
			o_press <= 1'b0;
		end else if (cnt == CW'(clock_pkg::DEBOUNCE_TICKS - 1)) begin
			cnt      <= '0;
			stable_q <= sync_q[1];
			// Only the press, not the release, makes a pulse
			o_press  <= sync_q[1];
		end else begin
			cnt     <= cnt + 1'b1;
			o_press <= 1'b0;
		end
	end

endmodule

//--- verilog/clock_control.sv
// Front-panel control state
//   Mode and field selection, alarm enable toggle
//   Steering of increment presses to time or alarm fields

`timescale 1ns/1ps

module clock_control (
	input  logic              clk,
	input  logic              rst_n,
	input  clock_pkg::btn_t   i_press,
	output clock_pkg::mode_e  o_mode,
	output clock_pkg::field_e o_field,
	output logic              o_alarm_en,
	output logic              o_run,
	output clock_pkg::edit_t  o_time_edit,
	output clock_pkg::edit_t  o_alarm_edit
);

	clock_pkg::edit_t inc_sel;

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_mode     <= clock_pkg::MODE_CLOCK;
			o_field    <= clock_pkg::FIELD_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (i_press.mode) begin
				case (o_mode)
					clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: o_mode <= clock_pkg::MODE_ALARM;
					default:               o_mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (i_press.field) begin
				case (o_field)
					clock_pkg::FIELD_SEC: o_field <= clock_pkg::FIELD_MIN;
					clock_pkg::FIELD_MIN: o_field <= clock_pkg::FIELD_HOUR;
					default:              o_field <= clock_pkg::FIELD_SEC;
				endcase
			end
			if (i_press.alarm_en) begin
				o_alarm_en <= ~o_alarm_en;
			end
		end
	end

	// Increment press onto the selected field
	always_comb begin
		inc_sel      = '0;
		inc_sel.sec  = i_press.inc && (o_field == clock_pkg::FIELD_SEC);
		inc_sel.min  = i_press.inc && (o_field == clock_pkg::FIELD_MIN);
		inc_sel.hour = i_press.inc && (o_field == clock_pkg::FIELD_HOUR);
	end

	assign o_time_edit  = (o_mode == clock_pkg::MODE_SETUP) ? inc_sel : '0;
	assign o_alarm_edit = (o_mode == clock_pkg::MODE_ALARM) ? inc_sel : '0;

	// Time is frozen only while it is being set
	assign o_run = (o_mode != clock_pkg::MODE_SETUP);

endmodule

//--- verilog/time_keeper.sv
// Time of day and alarm storage
//   Cascaded hour:minute:second counter with carry
//   Per-field edits with wrap and no carry
//   Alarm compare and latch
//   Display source select by mode

`timescale 1ns/1ps

module time_keeper (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_sec_tick,
	input  logic             i_run,
	input  clock_pkg::mode_e i_mode,
	input  clock_pkg::edit_t i_time_edit,
	input  clock_pkg::edit_t i_alarm_edit,
	input  logic             i_alarm_en,
	output clock_pkg::hms_t  o_disp,
	output logic             o_alarm_on
);

	clock_pkg::hms_t time_q;
	clock_pkg::hms_t alarm_q;

	// Step one count, back to zero past max
	function automatic logic [5:0] step(input logic [5:0] value, input logic [5:0] max);
		return (value >= max) ? 6'd0 : value + 6'd1;
	endfunction

	// ---------------------------------------------------------------------
	// Running time
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			time_q <= '0;
		end else if (i_sec_tick && i_run) begin
			time_q.sec <= step(time_q.sec, clock_pkg::SEC_MAX);
			if (time_q.sec == clock_pkg::SEC_MAX) begin
				time_q.min <= step(time_q.min, clock_pkg::SEC_MAX);
				if (time_q.min == clock_pkg::SEC_MAX) begin
					time_q.hour <= step(time_q.hour, clock_pkg::HOUR_MAX);
				end
			end
		end else begin
			// Edits only arrive in SETUP, where the tick is held off
			if (i_time_edit.sec) begin
				time_q.sec <= step(time_q.sec, clock_pkg::SEC_MAX);
			end
			if (i_time_edit.min) begin
				time_q.min <= step(time_q.min, clock_pkg::SEC_MAX);
			end
			if (i_time_edit.hour) begin
				time_q.hour <= step(time_q.hour, clock_pkg::HOUR_MAX);
			end
		end
	end

	// ---------------------------------------------------------------------
	// Alarm setting and latch
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			alarm_q <= '0;
		end else begin
			if (i_alarm_edit.sec) begin
				alarm_q.sec <= step(alarm_q.sec, clock_pkg::SEC_MAX);
			end
			if (i_alarm_edit.min) begin
				alarm_q.min <= step(alarm_q.min, clock_pkg::SEC_MAX);
			end
			if (i_alarm_edit.hour) begin
				alarm_q.hour <= step(alarm_q.hour, clock_pkg::HOUR_MAX);
			end
		end
	end

	// Stays on after the match until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_alarm_on <= 1'b0;
		end else if (!i_alarm_en) begin
			o_alarm_on <= 1'b0;
		end else if (time_q == alarm_q) begin
			o_alarm_on <= 1'b1;
		end
	end

	assign o_disp = (i_mode == clock_pkg::MODE_ALARM) ? alarm_q : time_q;

endmodule

//--- verilog/alarm_buzzer.sv
// Beeping buzzer drive
//   Beat and tone square waves from two dividers
//   Both held low while the alarm is off

`timescale 1ns/1ps

module alarm_buzzer (
	input  logic clk,
	input  logic rst_n,
	input  logic i_alarm_on,
	output logic o_buzz
);

	logic beat_tick;
	logic tone_tick;
	logic beat_q;
	logic tone_q;

	rate_divider #(.DIVIDE(clock_pkg::BEEP_TICKS)) u_beat_div (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (beat_tick)
	);

	rate_divider #(.DIVIDE(clock_pkg::TONE_TICKS)) u_tone_div (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (tone_tick)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			beat_q <= 1'b0;
			tone_q <= 1'b0;
		end else if (!i_alarm_on) begin
			beat_q <= 1'b0;
			tone_q <= 1'b0;
		end else begin
			beat_q <= beat_q ^ beat_tick;
			tone_q <= tone_q ^ tone_tick;
		end
	end

	// Tone only during the on half of the beat
	assign o_buzz = beat_q & tone_q;

endmodule

//--- verilog/seg_display.sv
// Six-digit multiplexed seven-segment driver
//   Scan index stepped by a divider strobe
//   Tens/units split and segment decode of the current field
//   Registered segment, decimal point and active-low digit enable

`timescale 1ns/1ps

module seg_display (
	input  logic                             clk,
	input  logic                             rst_n,
	input  clock_pkg::hms_t                  i_disp,
	input  clock_pkg::mode_e                 i_mode,
	input  clock_pkg::field_e                i_field,
	output clock_pkg::seg_t                  o_seg,
	output logic                             o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb
);

	logic            scan_tick;
	logic [2:0]      idx;
	logic            idx_valid;
	logic [5:0]      field_val;
	logic [3:0]      digit_val;

	function automatic clock_pkg::seg_t seg_decode(input logic [3:0] num);
		case (num)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return clock_pkg::SEG_BLANK;
		endcase
	endfunction

	rate_divider #(.DIVIDE(clock_pkg::SCAN_TICKS)) u_scan_div (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	// Index 7 out of reset means no digit yet, first strobe moves to 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			idx <= 3'd7;
		end else if (scan_tick) begin
			idx <= (idx >= 3'(clock_pkg::NUM_DIGITS - 1)) ? 3'd0 : idx + 3'd1;
		end
	end

	assign idx_valid = (idx < 3'(clock_pkg::NUM_DIGITS));

	// Digit pairs: 0/1 seconds, 2/3 minutes, 4/5 hours, odd digit is tens
	always_comb begin
		case (idx[2:1])
			2'd0:    field_val = i_disp.sec;
			2'd1:    field_val = i_disp.min;
			default: field_val = i_disp.hour;
		endcase
		digit_val = idx[0] ? 4'(field_val / 6'd10) : 4'(field_val % 6'd10);
	end

	// ---------------------------------------------------------------------
	// Output registers
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_seg     <= clock_pkg::SEG_BLANK;
			o_seg_dp  <= 1'b0;
			o_seg_enb <= '1;
		end else if (idx_valid) begin
			o_seg     <= seg_decode(digit_val);
			o_seg_dp  <= (i_mode != clock_pkg::MODE_CLOCK) && (idx[2:1] == 2'(i_field));
			o_seg_enb <= ~(clock_pkg::NUM_DIGITS'(1) << idx);
		end else begin
			o_seg     <= clock_pkg::SEG_BLANK;
			o_seg_dp  <= 1'b0;
			o_seg_enb <= '1;
		end
	end

endmodule

//--- verilog/digital_clock_top.sv
// Digital clock with alarm, top level
//   Button debouncers, seconds divider, control FSM,
//   time keeper, buzzer and display driver

`timescale 1ns/1ps

module digital_clock_top (
	input  logic                             clk,
	input  logic                             rst_n,
	input  clock_pkg::btn_t                  i_btn,
	output clock_pkg::seg_t                  o_seg,
	output logic                             o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb,
	output logic                             o_alarm,
	output logic                             o_buzz
);

	clock_pkg::btn_t   press;
	logic              sec_tick;
	clock_pkg::mode_e  mode;
	clock_pkg::field_e field;
	logic              alarm_en;
	logic              run;
	clock_pkg::edit_t  time_edit;
	clock_pkg::edit_t  alarm_edit;
	clock_pkg::hms_t   disp;

	// One debouncer per button bit
	for (genvar i = 0; i < $bits(clock_pkg::btn_t); i++) begin : g_btn
		button_debounce u_debounce (
			.clk     (clk),
			.rst_n   (rst_n),
			.i_btn   (i_btn[i]),
			.o_press (press[i])
		);
	end

	rate_divider #(.DIVIDE(clock_pkg::TICKS_PER_SEC)) u_sec_div (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	clock_control u_control (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_press      (press),
		.o_mode       (mode),
		.o_field      (field),
		.o_alarm_en   (alarm_en),
		.o_run        (run),
		.o_time_edit  (time_edit),
		.o_alarm_edit (alarm_edit)
	);

	time_keeper u_time (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_sec_tick   (sec_tick),
		.i_run        (run),
		.i_mode       (mode),
		.i_time_edit  (time_edit),
		.i_alarm_edit (alarm_edit),
		.i_alarm_en   (alarm_en),
		.o_disp       (disp),
		.o_alarm_on   (o_alarm)
	);

	alarm_buzzer u_buzzer (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_alarm_on (o_alarm),
		.o_buzz     (o_buzz)
	);

	seg_display u_display (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_disp    (disp),
		.i_mode    (mode),
		.i_field   (field),
		.o_seg     (o_seg),
		.o_seg_dp  (o_seg_dp),
		.o_seg_enb (o_seg_enb)
	);

endmodule

//--- verif/tb_digital_clock.sv
// Testbench for the digital clock top level
//   Clock, reset, cycle counter with timeout
//   LCG random source and button press driver
//   Reference model of mode, field, alarm enable, time and alarm
//   Display scan decoder and checks for setup, alarm edit, running time and alarm

`timescale 1ns/1ps

module tb_digital_clock;

	localparam int HOLD_CYCLES    = clock_pkg::DEBOUNCE_TICKS + 8;
	localparam int PRESS_CYCLES   = 2 * HOLD_CYCLES + 1;
	// Worst case from press to register change, and latency allowance for run start
	localparam int LAT            = clock_pkg::DEBOUNCE_TICKS + 5;
	localparam int TPS            = clock_pkg::TICKS_PER_SEC;
	localparam int SCAN_SAMPLES   = clock_pkg::NUM_DIGITS * clock_pkg::SCAN_TICKS + 2;
	// Scan starts this many cycles into a second so no time change lands in it
	localparam int SCAN_PHASE     = 4;
	localparam int DAY_SECS       = 86400;
	localparam int ALARM_LEAD     = 5;
	// At most about 1020 presses over all tests, with scans and waits on top
	localparam int MAX_PRESSES    = 1200;
	localparam int TIMEOUT_CYCLES = MAX_PRESSES * PRESS_CYCLES + 60 * TPS;

	localparam clock_pkg::btn_t BTN_MODE     = 4'b1000;
	localparam clock_pkg::btn_t BTN_FIELD    = 4'b0100;
	localparam clock_pkg::btn_t BTN_INC      = 4'b0010;
	localparam clock_pkg::btn_t BTN_ALARM_EN = 4'b0001;

	logic                             clk;
	logic                             rst_n;
	clock_pkg::btn_t                  i_btn;
	clock_pkg::seg_t                  o_seg;
	logic                             o_seg_dp;
	logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb;
	logic                             o_alarm;
	logic                             o_buzz;

	int          cyc = 0;
	int          rel_cyc = 0;
	int          run_cyc = 0;
	int          last_press_cyc = 0;
	int          last_scan_cyc = 0;
	int          error_count = 0;
	int          check_count = 0;
	int unsigned lcg_state = 34;

	// Model state with mode 0 CLOCK 1 SETUP 2 ALARM and field 0 sec 1 min 2 hour
	int              m_mode = 0;
	int              m_field = 0;
	bit              m_alarm_en = 1'b0;
	clock_pkg::hms_t m_time = '0;
	clock_pkg::hms_t m_alarm = '0;

	digital_clock_top DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_btn     (i_btn),
		.o_seg     (o_seg),
		.o_seg_dp  (o_seg_dp),
		.o_seg_enb (o_seg_enb),
		.o_alarm   (o_alarm),
		.o_buzz    (o_buzz)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc > TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ---------------------------------------------------------------------
	// Helpers
	// ---------------------------------------------------------------------
	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'((lcg_next() >> 8) % unsigned'(hi - lo + 1));
	endfunction

	function automatic int field_mod(input int f);
		return (f == 2) ? 24 : 60;
	endfunction

	function automatic int get_field(input clock_pkg::hms_t v, input int f);
		case (f)
			0:       return int'(v.sec);
			1:       return int'(v.min);
			default: return int'(v.hour);
		endcase
	endfunction

	function automatic clock_pkg::hms_t make_hms(input int h, input int m, input int s);
		clock_pkg::hms_t r;
		r.hour = 6'(h);
		r.min  = 6'(m);
		r.sec  = 6'(s);
		return r;
	endfunction

	// Step one field up by one with wrap and leave the others
	function automatic clock_pkg::hms_t bump_field(input clock_pkg::hms_t v, input int f);
		clock_pkg::hms_t r;
		r = v;
		case (f)
			0:       r.sec  = 6'((int'(v.sec) + 1) % 60);
			1:       r.min  = 6'((int'(v.min) + 1) % 60);
			default: r.hour = 6'((int'(v.hour) + 1) % 24);
		endcase
		return r;
	endfunction

	function automatic clock_pkg::hms_t add_secs(input clock_pkg::hms_t v, input int n);
		int total;
		total = (int'(v.hour) * 3600 + int'(v.min) * 60 + int'(v.sec) + n) % DAY_SECS;
		return make_hms(total / 3600, (total / 60) % 60, total % 60);
	endfunction

	// Decode segments a..g (MSB first) with both common shapes of 6, 7 and 9
	function automatic int seg_to_digit(input clock_pkg::seg_t s);
		case (s)
			7'b1111110:             return 0;
			7'b0110000:             return 1;
			7'b1101101:             return 2;
			7'b1111001:             return 3;
			7'b0110011:             return 4;
			7'b1011011:             return 5;
			7'b1011111, 7'b0011111: return 6;
			7'b1110000, 7'b1110010: return 7;
			7'b1111111:             return 8;
			7'b1111011, 7'b1110011: return 9;
			default:                return 15;
		endcase
	endfunction

	function automatic int dp_expect();
		return (m_mode == 0) ? 0 : (3 << (2 * m_field));
	endfunction

	task automatic fail_msg(input string text);
		error_count++;
		$display("at %0t: %s", $time, text);
	endtask

	task automatic check_int(input string name, input int exp, input int act);
		check_count++;
		if (exp != act) begin
			error_count++;
			$display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_hms(input string name, input clock_pkg::hms_t exp,
			input clock_pkg::hms_t act);
		check_count++;
		if (exp != act) begin
			error_count++;
			$display("error at %0t: o_seg (%s) expected %0d:%0d:%0d got %0d:%0d:%0d",
				$time, name, exp.hour, exp.min, exp.sec, act.hour, act.min, act.sec);
		end
	endtask

	// Running value must be base plus a tick count that fits the cycle range
	task automatic check_window(input string name, input clock_pkg::hms_t base,
			input int clo, input int chi, input clock_pkg::hms_t act);
		int nlo;
		int nhi;
		bit ok;
		nlo = (clo < 0) ? 0 : clo / TPS;
		nhi = (chi + TPS - 1) / TPS;
		ok  = 1'b0;
		for (int n = nlo; n <= nhi; n++) begin
			if (add_secs(base, n) == act) begin
				ok = 1'b1;
			end
		end
		check_count++;
		if (!ok) begin
			error_count++;
			$display("error at %0t: o_seg (%s) expected %0d:%0d:%0d plus %0d..%0d s got %0d:%0d:%0d",
				$time, name, base.hour, base.min, base.sec, nlo, nhi,
				act.hour, act.min, act.sec);
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && (o_seg_enb != '1) && ($countones(~o_seg_enb) != 1)) begin
			fail_msg($sformatf("digit enable %b is neither idle nor one-hot low", o_seg_enb));
		end
	end

	// ---------------------------------------------------------------------
	// Stimulus and display capture
	// ---------------------------------------------------------------------
	task automatic press(input clock_pkg::btn_t which);
		last_press_cyc = cyc;
		@(negedge clk);
		i_btn = which;
		repeat (HOLD_CYCLES) @(negedge clk);
		i_btn = '0;
		repeat (HOLD_CYCLES) @(negedge clk);
		if (which.mode) begin
			if (m_mode == 1) begin
				run_cyc = last_press_cyc;
			end
			m_mode = (m_mode + 1) % 3;
		end
		if (which.field) begin
			m_field = (m_field + 1) % 3;
		end
		if (which.inc && m_mode == 1) begin
			m_time = bump_field(m_time, m_field);
		end else if (which.inc && m_mode == 2) begin
			m_alarm = bump_field(m_alarm, m_field);
		end
		if (which.alarm_en) begin
			m_alarm_en = !m_alarm_en;
		end
	endtask

	task automatic select_field(input int f);
		while (m_field != f) begin
			press(BTN_FIELD);
		end
	endtask

	// Step each field of the edited value (time or alarm) to the target
	task automatic set_fields(input clock_pkg::hms_t target);
		int cur;
		int n;
		for (int f = 0; f < 3; f++) begin
			select_field(f);
			cur = (m_mode == 1) ? get_field(m_time, f) : get_field(m_alarm, f);
			n   = (get_field(target, f) - cur + field_mod(f)) % field_mod(f);
			repeat (n) press(BTN_INC);
		end
	endtask

	task automatic scan_display(output clock_pkg::hms_t val, output logic [5:0] dpm);
		int         dig [clock_pkg::NUM_DIGITS];
		logic [5:0] seen;
		int         d;
		seen = '0;
		dpm  = '0;
		d    = 0;
		for (int i = 0; i < clock_pkg::NUM_DIGITS; i++) begin
			dig[i] = 0;
		end
		@(negedge clk);
		while (((cyc - rel_cyc) % TPS) != SCAN_PHASE) @(negedge clk);
		last_scan_cyc = cyc;
		for (int s = 0; s < SCAN_SAMPLES; s++) begin
			if (o_seg_enb != '1) begin
				for (int i = 0; i < clock_pkg::NUM_DIGITS; i++) begin
					if (!o_seg_enb[i]) d = i;
				end
				dig[d]  = seg_to_digit(o_seg);
				dpm[d]  = o_seg_dp;
				seen[d] = 1'b1;
			end
			@(negedge clk);
		end
		if (seen != '1) begin
			fail_msg($sformatf("display scan showed only digits %b", seen));
		end
		for (int i = 0; i < clock_pkg::NUM_DIGITS; i++) begin
			if (dig[i] > 9) fail_msg($sformatf("digit %0d has no valid segment pattern", i));
		end
		val = make_hms(dig[5] * 10 + dig[4], dig[3] * 10 + dig[2], dig[1] * 10 + dig[0]);
	endtask

	task automatic check_static(input string name, input clock_pkg::hms_t exp);
		clock_pkg::hms_t seen;
		logic [5:0]      dpm;
		scan_display(seen, dpm);
		check_hms(name, exp, seen);
		check_int("o_seg_dp mask", dp_expect(), int'(dpm));
	endtask

	task automatic check_running(input string name);
		clock_pkg::hms_t seen;
		logic [5:0]      dpm;
		scan_display(seen, dpm);
		check_window(name, m_time, last_scan_cyc - run_cyc - LAT,
			last_scan_cyc + SCAN_SAMPLES - run_cyc, seen);
		check_int("o_seg_dp mask", dp_expect(), int'(dpm));
	endtask

	// From CLOCK into SETUP, then take the frozen time as the new model time
	task automatic enter_setup();
		clock_pkg::hms_t seen;
		logic [5:0]      dpm;
		press(BTN_MODE);
		scan_display(seen, dpm);
		check_window("frozen time", m_time, last_press_cyc - run_cyc - LAT,
			last_press_cyc - run_cyc + LAT, seen);
		check_int("o_seg_dp mask", dp_expect(), int'(dpm));
		m_time = seen;
	endtask

	// ---------------------------------------------------------------------
	// Test sequence
	// ---------------------------------------------------------------------
	initial begin
		clock_pkg::hms_t a;
		int              c0;
		int              edges;
		bit              flag;
		rst_n = 1'b0;
		i_btn = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n   = 1'b1;
		rel_cyc = cyc;
		run_cyc = cyc;

		// After reset
		check_int("o_alarm", 0, int'(o_alarm));
		check_int("o_buzz", 0, int'(o_buzz));
		check_int("o_seg_enb", 63, int'(o_seg_enb));
		check_static("reset display", '0);

		// Random increments per field in SETUP
		enter_setup();
		for (int f = 0; f < 3; f++) begin
			select_field(f);
			repeat (rand_range(0, 70)) press(BTN_INC);
		end
		check_static("set time", m_time);
		repeat (3 * TPS) @(negedge clk);
		check_static("frozen time", m_time);

		// ALARM edits leave the time alone
		press(BTN_MODE);
		for (int f = 0; f < 3; f++) begin
			select_field(f);
			repeat (rand_range(0, 70)) press(BTN_INC);
		end
		check_static("alarm display", m_alarm);
		press(BTN_MODE);
		check_running("time after alarm edit");

		// Run across midnight
		enter_setup();
		set_fields(make_hms(23, 59, rand_range(50, 57)));
		check_static("time before run", m_time);
		press(BTN_MODE);
		c0 = run_cyc;
		press(BTN_MODE);
		edges = rand_range(8, 14);
		while (cyc - c0 < edges * TPS) @(negedge clk);
		check_running("time after midnight");

		// Alarm match with enable
		enter_setup();
		press(BTN_MODE);
		a = make_hms(rand_range(0, 23), rand_range(0, 59), rand_range(0, 59));
		set_fields(a);
		check_static("alarm setting", a);
		press(BTN_MODE);
		enter_setup();
		set_fields(add_secs(a, DAY_SECS - ALARM_LEAD));
		press(BTN_MODE);
		c0 = run_cyc;
		press(BTN_MODE);
		press(BTN_ALARM_EN);
		check_int("o_alarm", 0, int'(o_alarm));
		while (!o_alarm && (cyc - c0) <= LAT + ALARM_LEAD * TPS + SCAN_SAMPLES) begin
			@(negedge clk);
		end
		if (!o_alarm) begin
			fail_msg("alarm output did not rise after the time reached the alarm");
		end else if (cyc - c0 < (ALARM_LEAD - 1) * TPS) begin
			fail_msg($sformatf("alarm output rose %0d cycles after run start", cyc - c0));
		end
		edges = 0;
		flag  = 1'b0;
		repeat (4 * clock_pkg::BEEP_TICKS) begin
			c0 = int'(o_buzz);
			@(negedge clk);
			if (int'(o_buzz) != c0) edges++;
			if (!o_alarm) flag = 1'b1;
		end
		if (edges < 2) fail_msg("buzzer did not toggle while the alarm was on");
		if (flag) fail_msg("alarm output dropped while still enabled");
		press(BTN_ALARM_EN);
		// Past the match the latch follows the enable
		check_int("o_alarm", int'(m_alarm_en), int'(o_alarm));
		check_int("o_buzz", 0, int'(o_buzz));

		// Same match with the alarm disabled
		enter_setup();
		set_fields(add_secs(a, DAY_SECS - 4));
		press(BTN_MODE);
		press(BTN_MODE);
		flag = 1'b0;
		repeat (6 * TPS) begin
			@(negedge clk);
			if ((o_alarm != m_alarm_en) || o_buzz) flag = 1'b1;
		end
		if (flag) fail_msg("alarm or buzzer went high with the alarm disabled");

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
verilog/clock_pkg.sv
verilog/rate_divider.sv
verilog/button_debounce.sv
verilog/clock_control.sv
verilog/time_keeper.sv
verilog/alarm_buzzer.sv
verilog/seg_display.sv
verilog/digital_clock_top.sv
verif/tb_digital_clock.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the testbench's pass line
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_digital_clock \
	-o tb_digital_clock && \
	./obj_dir/tb_digital_clock | tee /dev/stderr | grep -q "SIMULATION PASSED" && \
	echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }
